// ==== all.f ====
soc_periph_pkg.sv
ref_clk_sync.sv
periph_bus_decoder.sv
apb_gpio.sv
apb_soc_ctrl.sv
apb_timer_unit.sv
soc_peripherals.sv
tb_soc_peripherals.sv

// ==== apb_gpio.sv ====
// GPIO block on APB with direction, output, synchronized input and rising-edge interrupts
`timescale 1ns/100ps

module apb_gpio import soc_periph_pkg::*; #(
    parameter int NGPIO = 32
) (
    input  logic             clk_i,
    input  logic             rst_i,
    input  logic             psel_i,
    input  logic             penable_i,
    input  logic             pwrite_i,
    input  apb_addr_t        paddr_i,
    input  apb_data_t        pwdata_i,
    output apb_data_t        prdata_o,
    input  logic [NGPIO-1:0] gpio_in_i,
    output logic [NGPIO-1:0] gpio_out_o,
    output logic [NGPIO-1:0] gpio_dir_o,
    output logic             gpio_event_o
);

    logic [3:0]       reg_idx;
    logic             wr_en;
    logic             rd_en;
    logic [NGPIO-1:0] dir_q;
    logic [NGPIO-1:0] out_q;
    logic [NGPIO-1:0] inten_q;
    logic [NGPIO-1:0] status_q;
    logic [NGPIO-1:0] sync1_q;
    logic [NGPIO-1:0] sync2_q;
    logic [NGPIO-1:0] prev_q;
    logic [NGPIO-1:0] rise_det;
    logic             event_q;

    assign reg_idx = paddr_i[5:2];
    assign wr_en   = psel_i & penable_i & pwrite_i;
    assign rd_en   = psel_i & penable_i & ~pwrite_i;

    ////////////////////
    // Input path
    ////////////////////
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            sync1_q <= '0;
            sync2_q <= '0;
            prev_q  <= '0;
        end else begin
            sync1_q <= gpio_in_i;
            sync2_q <= sync1_q;
            prev_q  <= sync2_q;
        end
    end

    // Only enabled pins contribute
    assign rise_det = sync2_q & ~prev_q & inten_q;

    ////////////////////
    // Registers
    ////////////////////
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            dir_q    <= '0;
            out_q    <= '0;
            inten_q  <= '0;
            status_q <= '0;
            event_q  <= 1'b0;
        end else begin
            event_q <= |rise_det;
            if (wr_en && reg_idx == GPIO_PADDIR[5:2])
                dir_q <= pwdata_i[NGPIO-1:0];
            if (wr_en && reg_idx == GPIO_PADOUT[5:2])
                out_q <= pwdata_i[NGPIO-1:0];
            if (wr_en && reg_idx == GPIO_INTEN[5:2])
                inten_q <= pwdata_i[NGPIO-1:0];
            // Reading the status clears it, edges in the same cycle still land
            if (rd_en && reg_idx == GPIO_INTSTATUS[5:2])
                status_q <= rise_det;
            else
                status_q <= status_q | rise_det;
        end
    end

    always_comb begin
        prdata_o = '0;
        case (reg_idx)
            GPIO_PADDIR[5:2]:    prdata_o[NGPIO-1:0] = dir_q;
            GPIO_PADIN[5:2]:     prdata_o[NGPIO-1:0] = sync2_q;
            GPIO_PADOUT[5:2]:    prdata_o[NGPIO-1:0] = out_q;
            GPIO_INTEN[5:2]:     prdata_o[NGPIO-1:0] = inten_q;
            GPIO_INTSTATUS[5:2]: prdata_o[NGPIO-1:0] = status_q;
            default:             prdata_o = '0;
        endcase
    end

    assign gpio_dir_o   = dir_q;
    assign gpio_out_o   = out_q;
    assign gpio_event_o = event_q;

endmodule

// ==== apb_soc_ctrl.sv ====
// SoC control registers on APB for boot address, fetch enable, INFO word and JTAG exchange
`timescale 1ns/100ps

module apb_soc_ctrl import soc_periph_pkg::*; #(
    parameter int NB_CORES    = 4,
    parameter int NB_CLUSTERS = 1
) (
    input  logic       clk_i,
    input  logic       rst_i,
    input  logic       psel_i,
    input  logic       penable_i,
    input  logic       pwrite_i,
    input  apb_addr_t  paddr_i,
    input  apb_data_t  pwdata_i,
    output apb_data_t  prdata_o,
    input  logic       fc_fetch_en_valid_i,
    input  logic       fc_fetch_en_i,
    output apb_data_t  fc_bootaddr_o,
    output logic       fc_fetchen_o,
    input  logic [7:0] soc_jtag_reg_i,
    output logic [7:0] soc_jtag_reg_o
);

    // Cores in the upper half, clusters in the lower half
    localparam apb_data_t INFO_WORD = {16'(NB_CORES), 16'(NB_CLUSTERS)};

    logic [3:0] reg_idx;
    logic       wr_en;
    apb_data_t  bootaddr_q;
    logic       fetchen_q;
    logic [7:0] jtag_q;

    assign reg_idx = paddr_i[5:2];
    assign wr_en   = psel_i & penable_i & pwrite_i;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            bootaddr_q <= BOOT_ADDR_DEFAULT;
            fetchen_q  <= 1'b0;
            jtag_q     <= '0;
        end else begin
            if (wr_en && reg_idx == CTRL_BOOTADDR[5:2])
                bootaddr_q <= pwdata_i;
            // External fetch enable wins over the bus
            if (fc_fetch_en_valid_i)
                fetchen_q <= fc_fetch_en_i;
            else if (wr_en && reg_idx == CTRL_FETCHEN[5:2])
                fetchen_q <= pwdata_i[0];
            if (wr_en && reg_idx == CTRL_JTAGREG[5:2])
                jtag_q <= pwdata_i[7:0];
        end
    end

    always_comb begin
        prdata_o = '0;
        case (reg_idx)
            CTRL_INFO[5:2]:     prdata_o = INFO_WORD;
            CTRL_BOOTADDR[5:2]: prdata_o = bootaddr_q;
            CTRL_FETCHEN[5:2]:  prdata_o = {31'b0, fetchen_q};
            CTRL_JTAGREG[5:2]:  prdata_o = {16'b0, soc_jtag_reg_i, jtag_q};
            default:            prdata_o = '0;
        endcase
    end

    assign fc_bootaddr_o  = bootaddr_q;
    assign fc_fetchen_o   = fetchen_q;
    assign soc_jtag_reg_o = jtag_q;

endmodule

// ==== apb_timer_unit.sv ====
// 32-bit APB timer with compare wrap, counting clock cycles or reference clock rising edges
`timescale 1ns/100ps

module apb_timer_unit import soc_periph_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_i,
    input  logic      psel_i,
    input  logic      penable_i,
    input  logic      pwrite_i,
    input  apb_addr_t paddr_i,
    input  apb_data_t pwdata_i,
    output apb_data_t prdata_o,
    input  logic      ref_rise_i,
    output logic      irq_o
);

    logic [3:0] reg_idx;
    logic       wr_en;
    logic [2:0] cfg_q;
    apb_data_t  counter_q;
    apb_data_t  compare_q;
    logic       irq_q;
    logic       tick;
    logic       match;

    assign reg_idx = paddr_i[5:2];
    assign wr_en   = psel_i & penable_i & pwrite_i;

    ////////////////////
    // Tick and match
    ////////////////////
    // REFCLK mode counts synchronized rising edges, otherwise every clock
    assign tick  = cfg_q[TIMER_CFG_ENABLE] &
                   (cfg_q[TIMER_CFG_REFCLK] ? ref_rise_i : 1'b1);
    assign match = (counter_q == compare_q);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            cfg_q     <= '0;
            counter_q <= '0;
            compare_q <= '0;
            irq_q     <= 1'b0;
        end else begin
            irq_q <= 1'b0;
            if (wr_en && reg_idx == TIMER_CFG[5:2])
                cfg_q <= pwdata_i[2:0];
            if (wr_en && reg_idx == TIMER_COMPARE[5:2])
                compare_q <= pwdata_i;
            // A bus write to the counter takes precedence over the tick
            if (wr_en && reg_idx == TIMER_COUNTER[5:2]) begin
                counter_q <= pwdata_i;
            end else if (tick) begin
                if (match) begin
                    counter_q <= '0;
                    irq_q     <= cfg_q[TIMER_CFG_IRQEN];
                end else begin
                    counter_q <= counter_q + 32'd1;
                end
            end
        end
    end

    always_comb begin
        prdata_o = '0;
        case (reg_idx)
            TIMER_CFG[5:2]:     prdata_o = {29'b0, cfg_q};
            TIMER_COUNTER[5:2]: prdata_o = counter_q;
            TIMER_COMPARE[5:2]: prdata_o = compare_q;
            default:            prdata_o = '0;
        endcase
    end

    assign irq_o = irq_q;

endmodule

// ==== periph_bus_decoder.sv ====
// Splits the incoming APB port into per-region selects and returns read data and error status
`timescale 1ns/100ps

module periph_bus_decoder import soc_periph_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_i,
    input  logic      psel_i,
    input  logic      penable_i,
    input  apb_addr_t paddr_i,
    output logic      gpio_psel_o,
    output logic      ctrl_psel_o,
    output logic      timer_psel_o,
    input  apb_data_t gpio_prdata_i,
    input  apb_data_t ctrl_prdata_i,
    input  apb_data_t timer_prdata_i,
    output apb_data_t prdata_o,
    output logic      pready_o,
    output logic      pslverr_o
);

    logic [REGION_WIDTH-1:0] region;
    logic                    gpio_hit;
    logic                    ctrl_hit;
    logic                    timer_hit;
    logic                    mapped;
    logic                    access;

    assign region    = paddr_i[REGION_LSB +: REGION_WIDTH];
    assign gpio_hit  = (region == REGION_GPIO);
    assign ctrl_hit  = (region == REGION_SOC_CTRL);
    assign timer_hit = (region == REGION_TIMER);
    assign mapped    = gpio_hit | ctrl_hit | timer_hit;

    assign gpio_psel_o  = psel_i & gpio_hit;
    assign ctrl_psel_o  = psel_i & ctrl_hit;
    assign timer_psel_o = psel_i & timer_hit;

    // Read data mux, unmapped regions read as zero
    always_comb begin
        prdata_o = '0;
        case (region)
            REGION_GPIO:     prdata_o = gpio_prdata_i;
            REGION_SOC_CTRL: prdata_o = ctrl_prdata_i;
            REGION_TIMER:    prdata_o = timer_prdata_i;
            default:         prdata_o = '0;
        endcase
    end

    // All slaves are zero-wait, so every access cycle completes
    assign access    = psel_i & penable_i;
    assign pready_o  = access;
    assign pslverr_o = access & ~mapped;

    ////////////////////
    // Checks
    ////////////////////
    // Access phase must follow a setup phase of the same transfer
    a_penable_after_setup: assert property (@(posedge clk_i) disable iff (rst_i)
        $rose(penable_i) |-> psel_i && $past(psel_i));

endmodule

// ==== ref_clk_sync.sv ====
// Brings the slow reference clock into the system clock domain as rise and fall strobes
`timescale 1ns/100ps

module ref_clk_sync (
    input  logic clk_i,
    input  logic rst_i,
    input  logic slow_clk_i,
    output logic ref_rise_o,
    output logic ref_fall_o
);

    // [0] and [1] form the synchronizer, [2] holds the previous level
    logic [2:0] sync_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            sync_q <= '0;
        end else begin
            sync_q <= {sync_q[1:0], slow_clk_i};
        end
    end

    // Compare the settled level with the one before it
    assign ref_rise_o = sync_q[1] & ~sync_q[2];
    assign ref_fall_o = ~sync_q[1] & sync_q[2];

    ////////////////////
    // Checks
    ////////////////////
    // The reference clock holds each level for more than one system clock
    a_edges_spaced: assert property (@(posedge clk_i) disable iff (rst_i)
        (ref_rise_o || ref_fall_o) |=> !(ref_rise_o || ref_fall_o));

endmodule

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator and run it; status follows the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module tb_soc_peripherals \
    -o tb_soc_peripherals

out=$(./obj_dir/tb_soc_peripherals) || true
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -q '^RESULT: PASS$'

// ==== soc_periph_pkg.sv ====
// Shared bus types, address map, register offsets and event positions, imported by each RTL block
package soc_periph_pkg;

    ////////////////////
    // Bus types
    ////////////////////
    typedef logic [31:0] apb_addr_t;
    typedef logic [31:0] apb_data_t;
    typedef logic [31:0] fc_event_t;

    ////////////////////
    // Address map
    ////////////////////
    // Region select field is paddr[15:12]
    localparam int REGION_LSB   = 12;
    localparam int REGION_WIDTH = 4;

    localparam logic [REGION_WIDTH-1:0] REGION_GPIO     = 4'd0;
    localparam logic [REGION_WIDTH-1:0] REGION_SOC_CTRL = 4'd1;
    localparam logic [REGION_WIDTH-1:0] REGION_TIMER    = 4'd2;

    // Byte offsets inside each region, blocks decode bits 5:2
    localparam logic [7:0] GPIO_PADDIR    = 8'h00;
    localparam logic [7:0] GPIO_PADIN     = 8'h04;
    localparam logic [7:0] GPIO_PADOUT    = 8'h08;
    localparam logic [7:0] GPIO_INTEN     = 8'h0C;
    localparam logic [7:0] GPIO_INTSTATUS = 8'h10;

    localparam logic [7:0] CTRL_INFO      = 8'h00;
    localparam logic [7:0] CTRL_BOOTADDR  = 8'h04;
    localparam logic [7:0] CTRL_FETCHEN   = 8'h08;
    localparam logic [7:0] CTRL_JTAGREG   = 8'h0C;

    localparam logic [7:0] TIMER_CFG      = 8'h00;
    localparam logic [7:0] TIMER_COUNTER  = 8'h04;
    localparam logic [7:0] TIMER_COMPARE  = 8'h08;

    // Timer configuration bits
    localparam int TIMER_CFG_ENABLE = 0;
    localparam int TIMER_CFG_IRQEN  = 1;
    localparam int TIMER_CFG_REFCLK = 2;

    localparam apb_data_t BOOT_ADDR_DEFAULT = 32'h1A00_0080;

    ////////////////////
    // Event word bits
    ////////////////////
    localparam int EVT_DMA_PE  = 8;
    localparam int EVT_DMA_IRQ = 9;
    localparam int EVT_TIMER   = 10;
    localparam int EVT_PF      = 12;
    localparam int EVT_REF_CLK = 14;
    localparam int EVT_GPIO    = 15;

endpackage

// ==== soc_peripherals.sv ====
// Top of the peripheral subsystem, connects decoder, register blocks and the event word
`timescale 1ns/100ps

module soc_peripherals import soc_periph_pkg::*; #(
    parameter int NGPIO       = 32,
    parameter int NB_CORES    = 4,
    parameter int NB_CLUSTERS = 1
) (
    input  logic             clk_i,
    input  logic             rst_i,
    input  logic             slow_clk_i,

    // APB slave port
    input  apb_addr_t        paddr_i,
    input  apb_data_t        pwdata_i,
    input  logic             pwrite_i,
    input  logic             psel_i,
    input  logic             penable_i,
    output apb_data_t        prdata_o,
    output logic             pready_o,
    output logic             pslverr_o,

    input  logic             fc_fetch_en_valid_i,
    input  logic             fc_fetch_en_i,
    output apb_data_t        fc_bootaddr_o,
    output logic             fc_fetchen_o,
    input  logic [7:0]       soc_jtag_reg_i,
    output logic [7:0]       soc_jtag_reg_o,

    input  logic [NGPIO-1:0] gpio_in_i,
    output logic [NGPIO-1:0] gpio_out_o,
    output logic [NGPIO-1:0] gpio_dir_o,

    input  logic             dma_pe_evt_i,
    input  logic             dma_pe_irq_i,
    input  logic             pf_evt_i,
    output fc_event_t        fc_events_o
);

    logic      gpio_psel;
    logic      ctrl_psel;
    logic      timer_psel;
    apb_data_t gpio_prdata;
    apb_data_t ctrl_prdata;
    apb_data_t timer_prdata;
    logic      ref_rise;
    logic      ref_fall;
    logic      timer_irq;
    logic      gpio_event;

    ////////////////////
    // Event word
    ////////////////////
    // Unlisted bits are reserved and stay low
    always_comb begin
        fc_events_o              = '0;
        fc_events_o[EVT_DMA_PE]  = dma_pe_evt_i;
        fc_events_o[EVT_DMA_IRQ] = dma_pe_irq_i;
        fc_events_o[EVT_TIMER]   = timer_irq;
        fc_events_o[EVT_PF]      = pf_evt_i;
        fc_events_o[EVT_REF_CLK] = ref_rise | ref_fall;
        fc_events_o[EVT_GPIO]    = gpio_event;
    end

    ref_clk_sync i_ref_clk_sync (
        .clk_i      ( clk_i      ),
        .rst_i      ( rst_i      ),
        .slow_clk_i ( slow_clk_i ),
        .ref_rise_o ( ref_rise   ),
        .ref_fall_o ( ref_fall   )
    );

    ////////////////////
    // Peripheral bus
    ////////////////////
    periph_bus_decoder i_periph_bus_decoder (
        .clk_i          ( clk_i        ),
        .rst_i          ( rst_i        ),
        .psel_i         ( psel_i       ),
        .penable_i      ( penable_i    ),
        .paddr_i        ( paddr_i      ),
        .gpio_psel_o    ( gpio_psel    ),
        .ctrl_psel_o    ( ctrl_psel    ),
        .timer_psel_o   ( timer_psel   ),
        .gpio_prdata_i  ( gpio_prdata  ),
        .ctrl_prdata_i  ( ctrl_prdata  ),
        .timer_prdata_i ( timer_prdata ),
        .prdata_o       ( prdata_o     ),
        .pready_o       ( pready_o     ),
        .pslverr_o      ( pslverr_o    )
    );

    apb_gpio #(
        .NGPIO ( NGPIO )
    ) i_apb_gpio (
        .clk_i        ( clk_i       ),
        .rst_i        ( rst_i       ),
        .psel_i       ( gpio_psel   ),
        .penable_i    ( penable_i   ),
        .pwrite_i     ( pwrite_i    ),
        .paddr_i      ( paddr_i     ),
        .pwdata_i     ( pwdata_i    ),
        .prdata_o     ( gpio_prdata ),
        .gpio_in_i    ( gpio_in_i   ),
        .gpio_out_o   ( gpio_out_o  ),
        .gpio_dir_o   ( gpio_dir_o  ),
        .gpio_event_o ( gpio_event  )
    );

    apb_soc_ctrl #(
        .NB_CORES    ( NB_CORES    ),
        .NB_CLUSTERS ( NB_CLUSTERS )
    ) i_apb_soc_ctrl (
        .clk_i               ( clk_i               ),
        .rst_i               ( rst_i               ),
        .psel_i              ( ctrl_psel           ),
        .penable_i           ( penable_i           ),
        .pwrite_i            ( pwrite_i            ),
        .paddr_i             ( paddr_i             ),
        .pwdata_i            ( pwdata_i            ),
        .prdata_o            ( ctrl_prdata         ),
        .fc_fetch_en_valid_i ( fc_fetch_en_valid_i ),
        .fc_fetch_en_i       ( fc_fetch_en_i       ),
        .fc_bootaddr_o       ( fc_bootaddr_o       ),
        .fc_fetchen_o        ( fc_fetchen_o        ),
        .soc_jtag_reg_i      ( soc_jtag_reg_i      ),
        .soc_jtag_reg_o      ( soc_jtag_reg_o      )
    );

    apb_timer_unit i_apb_timer_unit (
        .clk_i      ( clk_i        ),
        .rst_i      ( rst_i        ),
        .psel_i     ( timer_psel   ),
        .penable_i  ( penable_i    ),
        .pwrite_i   ( pwrite_i     ),
        .paddr_i    ( paddr_i      ),
        .pwdata_i   ( pwdata_i     ),
        .prdata_o   ( timer_prdata ),
        .ref_rise_i ( ref_rise     ),
        .irq_o      ( timer_irq    )
    );

endmodule

// ==== tb_soc_peripherals.sv ====
// Directed testbench for the peripheral subsystem, run as top with the sources listed in all.f
`timescale 1ns/100ps

module tb_soc_peripherals import soc_periph_pkg::*;;

    localparam int NGPIO       = 32;
    localparam int NB_CORES    = 4;
    localparam int NB_CLUSTERS = 1;
    localparam int MAX_WAITS   = 4;
    localparam int K_WINDOWS   = 10;
    localparam int N_MAX       = 12;
    localparam int T_MAX       = 13;
    localparam int HOLD_CYCLES = 5;
    // Sum of the per-test budgets with a wide margin on top
    localparam int WATCHDOG_CYCLES =
        4 * (300 + K_WINDOWS * (N_MAX + 1) + T_MAX * HOLD_CYCLES + 200);

    logic             clk_i = 1'b0;
    logic             rst_i;
    logic             slow_clk_i;
    apb_addr_t        paddr_i;
    apb_data_t        pwdata_i;
    logic             pwrite_i;
    logic             psel_i;
    logic             penable_i;
    apb_data_t        prdata_o;
    logic             pready_o;
    logic             pslverr_o;
    logic             fc_fetch_en_valid_i;
    logic             fc_fetch_en_i;
    apb_data_t        fc_bootaddr_o;
    logic             fc_fetchen_o;
    logic [7:0]       soc_jtag_reg_i;
    logic [7:0]       soc_jtag_reg_o;
    logic [NGPIO-1:0] gpio_in_i;
    logic [NGPIO-1:0] gpio_out_o;
    logic [NGPIO-1:0] gpio_dir_o;
    logic             dma_pe_evt_i;
    logic             dma_pe_irq_i;
    logic             pf_evt_i;
    fc_event_t        fc_events_o;

    int   seed = 32'h068e_b569;
    int   error_count = 0;
    int   tests_passed = 0;
    int   tests_failed = 0;
    logic last_slverr;
    int   timer_pulses = 0;
    int   ref_pulses = 0;
    int   gpio_pulses = 0;

    soc_peripherals #(
        .NGPIO       ( NGPIO       ),
        .NB_CORES    ( NB_CORES    ),
        .NB_CLUSTERS ( NB_CLUSTERS )
    ) i_soc_peripherals (
        .clk_i               ( clk_i               ),
        .rst_i               ( rst_i               ),
        .slow_clk_i          ( slow_clk_i          ),
        .paddr_i             ( paddr_i             ),
        .pwdata_i            ( pwdata_i            ),
        .pwrite_i            ( pwrite_i            ),
        .psel_i              ( psel_i              ),
        .penable_i           ( penable_i           ),
        .prdata_o            ( prdata_o            ),
        .pready_o            ( pready_o            ),
        .pslverr_o           ( pslverr_o           ),
        .fc_fetch_en_valid_i ( fc_fetch_en_valid_i ),
        .fc_fetch_en_i       ( fc_fetch_en_i       ),
        .fc_bootaddr_o       ( fc_bootaddr_o       ),
        .fc_fetchen_o        ( fc_fetchen_o        ),
        .soc_jtag_reg_i      ( soc_jtag_reg_i      ),
        .soc_jtag_reg_o      ( soc_jtag_reg_o      ),
        .gpio_in_i           ( gpio_in_i           ),
        .gpio_out_o          ( gpio_out_o          ),
        .gpio_dir_o          ( gpio_dir_o          ),
        .dma_pe_evt_i        ( dma_pe_evt_i        ),
        .dma_pe_irq_i        ( dma_pe_irq_i        ),
        .pf_evt_i            ( pf_evt_i            ),
        .fc_events_o         ( fc_events_o         )
    );

    always #50 clk_i = ~clk_i;

    // Event pulses last one cycle, so the falling edge sees each one once
    always @(negedge clk_i) begin
        if (fc_events_o[EVT_TIMER])
            timer_pulses++;
        if (fc_events_o[EVT_REF_CLK])
            ref_pulses++;
        if (fc_events_o[EVT_GPIO])
            gpio_pulses++;
    end

    ////////////////////
    // Helpers
    ////////////////////
    function automatic apb_addr_t reg_addr(input logic [REGION_WIDTH-1:0] region,
                                           input logic [7:0] offset);
        apb_addr_t addr;
        addr = '0;
        addr[REGION_LSB +: REGION_WIDTH] = region;
        addr[7:0] = offset;
        return addr;
    endfunction

    task automatic compare_value(input string what, input apb_data_t got, input apb_data_t exp);
        assert (got === exp) else begin
            $display("mismatch at %0d ns: %s is %h, expected %h", $time, what, got, exp);
            error_count++;
        end
    endtask

    task automatic expect_in_range(input string what, input int got, input int lo, input int hi);
        assert (got >= lo && got <= hi) else begin
            $display("mismatch at %0d ns: %s is %0d, expected %0d to %0d",
                     $time, what, got, lo, hi);
            error_count++;
        end
    endtask

    task automatic bus_transfer(input apb_addr_t addr, input logic is_write,
                                input apb_data_t wdata, output apb_data_t rdata);
        int waits;
        waits = 0;
        @(posedge clk_i);
        #10;
        psel_i    = 1'b1;
        penable_i = 1'b0;
        pwrite_i  = is_write;
        paddr_i   = addr;
        pwdata_i  = wdata;
        @(posedge clk_i);
        #10;
        penable_i = 1'b1;
        @(negedge clk_i);
        while (!pready_o && waits < MAX_WAITS) begin
            waits++;
            @(negedge clk_i);
        end
        assert (pready_o) else begin
            $display("APB transfer to %h got no pready within %0d cycles", addr, MAX_WAITS);
            error_count++;
        end
        rdata       = prdata_o;
        last_slverr = pslverr_o;
        @(posedge clk_i);
        #10;
        psel_i    = 1'b0;
        penable_i = 1'b0;
        pwrite_i  = 1'b0;
    endtask

    task automatic apb_write(input apb_addr_t addr, input apb_data_t data);
        apb_data_t unused;
        bus_transfer(addr, 1'b1, data, unused);
    endtask

    task automatic apb_read(input apb_addr_t addr, output apb_data_t data);
        bus_transfer(addr, 1'b0, '0, data);
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (error_count == errors_before) begin
            tests_passed++;
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: failed with %0d errors", name, error_count - errors_before);
        end
    endtask

    ////////////////////
    // Tests
    ////////////////////
    task automatic soc_ctrl_regs();
        int        errs;
        apb_data_t rd;
        apb_data_t boot;
        logic [7:0] jtag_wr;
        errs = error_count;
        compare_value("boot address after reset", fc_bootaddr_o, BOOT_ADDR_DEFAULT);
        compare_value("fetch enable after reset", {31'b0, fc_fetchen_o}, '0);
        apb_read(reg_addr(REGION_SOC_CTRL, CTRL_INFO), rd);
        compare_value("INFO", rd, (apb_data_t'(NB_CORES) << 16) | apb_data_t'(NB_CLUSTERS));
        compare_value("pslverr on a mapped read", {31'b0, last_slverr}, '0);
        boot = $random(seed);
        apb_write(reg_addr(REGION_SOC_CTRL, CTRL_BOOTADDR), boot);
        compare_value("fc_bootaddr_o", fc_bootaddr_o, boot);
        apb_read(reg_addr(REGION_SOC_CTRL, CTRL_BOOTADDR), rd);
        compare_value("BOOTADDR readback", rd, boot);
        apb_write(reg_addr(REGION_SOC_CTRL, CTRL_FETCHEN), 32'd1);
        compare_value("fetch enable after write", {31'b0, fc_fetchen_o}, 32'd1);
        // External valid pulse with the enable low
        fc_fetch_en_valid_i = 1'b1;
        fc_fetch_en_i       = 1'b0;
        @(posedge clk_i);
        #10;
        fc_fetch_en_valid_i = 1'b0;
        compare_value("fetch enable after valid pulse", {31'b0, fc_fetchen_o}, '0);
        soc_jtag_reg_i = 8'($random(seed));
        jtag_wr = 8'($random(seed));
        apb_write(reg_addr(REGION_SOC_CTRL, CTRL_JTAGREG), {24'b0, jtag_wr});
        compare_value("soc_jtag_reg_o", {24'b0, soc_jtag_reg_o}, {24'b0, jtag_wr});
        apb_read(reg_addr(REGION_SOC_CTRL, CTRL_JTAGREG), rd);
        compare_value("JTAGREG readback", rd, {16'b0, soc_jtag_reg_i, jtag_wr});
        report_test("soc control", errs);
    endtask

    task automatic gpio_regs();
        int        errs;
        apb_data_t rd;
        apb_data_t val;
        errs = error_count;
        val = $random(seed);
        apb_write(reg_addr(REGION_GPIO, GPIO_PADDIR), val);
        compare_value("gpio_dir_o", gpio_dir_o, val);
        val = $random(seed);
        apb_write(reg_addr(REGION_GPIO, GPIO_PADOUT), val);
        compare_value("gpio_out_o", gpio_out_o, val);
        val = $random(seed);
        gpio_in_i = val;
        repeat (3) @(posedge clk_i);
        #10;
        apb_read(reg_addr(REGION_GPIO, GPIO_PADIN), rd);
        compare_value("PADIN", rd, val);
        report_test("gpio registers", errs);
    endtask

    task automatic gpio_interrupts();
        int        errs;
        apb_data_t rd;
        apb_data_t mask;
        apb_data_t raised;
        errs = error_count;
        // Second round runs with every pin masked
        for (int round = 0; round < 2; round++) begin
            gpio_in_i = '0;
            repeat (4) @(posedge clk_i);
            #10;
            mask = (round == 0) ? $random(seed) : '0;
            apb_write(reg_addr(REGION_GPIO, GPIO_INTEN), mask);
            gpio_pulses = 0;
            raised = $random(seed);
            gpio_in_i = raised;
            repeat (5) @(posedge clk_i);
            #10;
            apb_read(reg_addr(REGION_GPIO, GPIO_INTSTATUS), rd);
            compare_value("INTSTATUS first read", rd, raised & mask);
            apb_read(reg_addr(REGION_GPIO, GPIO_INTSTATUS), rd);
            compare_value("INTSTATUS second read", rd, '0);
            compare_value("GPIO event seen", {31'b0, gpio_pulses > 0},
                          {31'b0, (raised & mask) != 0});
        end
        report_test("gpio interrupts", errs);
    endtask

    task automatic timer_clock_mode();
        int        errs;
        int        n_cmp;
        int        pulses;
        apb_data_t rd;
        errs = error_count;
        n_cmp = 5 + ($random(seed) & 7);
        apb_write(reg_addr(REGION_TIMER, TIMER_COMPARE), apb_data_t'(n_cmp));
        apb_write(reg_addr(REGION_TIMER, TIMER_COUNTER), '0);
        apb_write(reg_addr(REGION_TIMER, TIMER_CFG),
                  (32'd1 << TIMER_CFG_ENABLE) | (32'd1 << TIMER_CFG_IRQEN));
        timer_pulses = 0;
        repeat (K_WINDOWS * (n_cmp + 1)) @(posedge clk_i);
        #10;
        pulses = timer_pulses;
        expect_in_range("timer pulses in window", pulses, K_WINDOWS - 1, K_WINDOWS + 1);
        apb_write(reg_addr(REGION_TIMER, TIMER_CFG), '0);
        apb_read(reg_addr(REGION_TIMER, TIMER_COUNTER), rd);
        expect_in_range("COUNTER after disable", int'(rd), 0, n_cmp);
        report_test("timer clock mode", errs);
    endtask

    task automatic ref_clock_path();
        int        errs;
        int        toggles;
        apb_data_t rd;
        errs = error_count;
        toggles = 6 + ($random(seed) & 7);
        apb_write(reg_addr(REGION_TIMER, TIMER_COMPARE), 32'hFFFF_FFFF);
        apb_write(reg_addr(REGION_TIMER, TIMER_COUNTER), '0);
        apb_write(reg_addr(REGION_TIMER, TIMER_CFG),
                  (32'd1 << TIMER_CFG_ENABLE) | (32'd1 << TIMER_CFG_REFCLK));
        ref_pulses = 0;
        for (int i = 0; i < toggles; i++) begin
            slow_clk_i = ~slow_clk_i;
            repeat (HOLD_CYCLES) @(posedge clk_i);
            #10;
        end
        compare_value("reference edge pulses", apb_data_t'(ref_pulses), apb_data_t'(toggles));
        // Level starts low, so odd toggles are the rising ones
        apb_read(reg_addr(REGION_TIMER, TIMER_COUNTER), rd);
        compare_value("COUNTER in reference mode", rd, apb_data_t'((toggles + 1) / 2));
        report_test("reference clock path", errs);
    endtask

    task automatic passthru_and_errors();
        int        errs;
        apb_data_t rd;
        errs = error_count;
        dma_pe_evt_i = 1'b1;
        @(negedge clk_i);
        compare_value("events with dma_pe_evt_i", fc_events_o, 32'd1 << EVT_DMA_PE);
        @(posedge clk_i);
        #10;
        dma_pe_evt_i = 1'b0;
        dma_pe_irq_i = 1'b1;
        @(negedge clk_i);
        compare_value("events with dma_pe_irq_i", fc_events_o, 32'd1 << EVT_DMA_IRQ);
        @(posedge clk_i);
        #10;
        dma_pe_irq_i = 1'b0;
        pf_evt_i     = 1'b1;
        @(negedge clk_i);
        compare_value("events with pf_evt_i", fc_events_o, 32'd1 << EVT_PF);
        @(posedge clk_i);
        #10;
        pf_evt_i = 1'b0;
        @(negedge clk_i);
        compare_value("events when idle", fc_events_o, '0);
        apb_read(reg_addr(4'd5, 8'h00), rd);
        compare_value("pslverr on region 5", {31'b0, last_slverr}, 32'd1);
        compare_value("read data on region 5", rd, '0);
        report_test("pass-through and errors", errs);
    endtask

    ////////////////////
    // Main sequence
    ////////////////////
    initial begin
        rst_i               = 1'b1;
        slow_clk_i          = 1'b0;
        paddr_i             = '0;
        pwdata_i            = '0;
        pwrite_i            = 1'b0;
        psel_i              = 1'b0;
        penable_i           = 1'b0;
        fc_fetch_en_valid_i = 1'b0;
        fc_fetch_en_i       = 1'b0;
        soc_jtag_reg_i      = '0;
        gpio_in_i           = '0;
        dma_pe_evt_i        = 1'b0;
        dma_pe_irq_i        = 1'b0;
        pf_evt_i            = 1'b0;
        repeat (2) @(posedge clk_i);
        #10;
        rst_i = 1'b0;

        soc_ctrl_regs();
        gpio_regs();
        gpio_interrupts();
        timer_clock_mode();
        ref_clock_path();
        passthru_and_errors();

        $display("tests passed: %0d, failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && error_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_i);
        $display("timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule
